// File: hdl/vmem_consts.svh
`ifndef VMEM_CONSTS_SVH
`define VMEM_CONSTS_SVH

// video memory geometry

`define VMEM_NBANKS	4	// banks sharing the arbiter
`define VMEM_DW		16	// data word width
`define VMEM_BANK_AW	14	// word address inside one bank
`define VMEM_PA_W	16	// peripheral address, top two bits pick the bank
`define VMEM_CA_W	15	// cpu address, bit 14 picks bank 1 or 2
`define VMEM_MW		2	// one mask bit per byte

// bank-select field of a peripheral address
`define VMEM_BSEL_W	(`VMEM_PA_W - `VMEM_BANK_AW)

// words per bank
`define VMEM_BANK_WORDS	(1 << `VMEM_BANK_AW)

`endif

// File: hdl/vmem_bus_pkg.sv
`include "vmem_consts.svh"

package vmem_bus_pkg;

	// one peripheral transfer, flash uses both fields
	// sprite and background only drive the address
	typedef struct packed
	{
		logic [`VMEM_PA_W-1:0] addr;	// bank select + word address
		logic [`VMEM_DW-1:0] wdata;	// flash write data
	} periph_req_t;			// 32 bits

	// cpu access, retried by the cpu until success
	typedef struct packed
	{
		logic [`VMEM_CA_W-1:0] addr;	// bit 14 = bank 2
		logic [`VMEM_DW-1:0] wdata;	// write data
		logic wr;			// write strobe
		logic [`VMEM_MW-1:0] mask;	// byte enables
	} cpu_req_t;			// 34 bits

	// what one bank ram sees from its arbiter
	typedef struct packed
	{
		logic [`VMEM_BANK_AW-1:0] addr;	// word address in bank
		logic [`VMEM_DW-1:0] din;	// write data
		logic [`VMEM_MW-1:0] mask;	// byte enables
		logic wr;			// write this edge
	} bank_port_t;			// 33 bits

endpackage

// File: hdl/vmem_arb_pkg.sv
package vmem_arb_pkg;

	// bank owner, same order as the old mux selects
	typedef enum logic [1:0]
	{
		OWN_CPU   = 2'd0,	// default owner
		OWN_FLASH = 2'd1,	// loader, writes
		OWN_BG    = 2'd2,	// background engine, reads
		OWN_SPR   = 2'd3	// sprite engine, reads
	} owner_e;

	// per bank arbiter state
	typedef enum logic [1:0]
	{
		ST_CPU     = 2'd0,	// cpu owns, grants allowed
		ST_HELD    = 2'd1,	// a peripheral holds the bank
		ST_RELEASE = 2'd2	// back to cpu, one cycle without grant
	} arb_state_e;

endpackage

// File: hdl/req_decoder.sv
`timescale 1ns/100ps
`include "vmem_consts.svh"

module req_decoder
(
	input CLK,
	input rst_n,

	input spr_req,
	input [`VMEM_PA_W-1:0] spr_addr,
	input bg_req,
	input [`VMEM_PA_W-1:0] bg_addr,
	input fl_req,
	input vmem_bus_pkg::periph_req_t fl_xfer,

	output logic [`VMEM_NBANKS-1:0] bank_fl_req,	// one line per bank
	output logic [`VMEM_NBANKS-1:0] bank_bg_req,
	output logic [`VMEM_NBANKS-1:0] bank_spr_req,
	output logic [`VMEM_BANK_AW-1:0] spr_word,	// captured word addresses
	output logic [`VMEM_BANK_AW-1:0] bg_word,
	output vmem_bus_pkg::periph_req_t fl_word	// captured flash transfer
);

localparam logic [`VMEM_NBANKS-1:0] SPR_REACH = 4'b0110;	// banks 2 and 3
localparam logic [`VMEM_NBANKS-1:0] BG_REACH  = 4'b1010;	// banks 2 and 4

// top address bits to a one-hot bank line
function automatic logic [`VMEM_NBANKS-1:0] bank_dec(input logic [`VMEM_PA_W-1:0] addr);
	logic [`VMEM_NBANKS-1:0] onehot;
	onehot = '0;
	onehot[addr[`VMEM_PA_W-1:`VMEM_BANK_AW]] = 1'b1;
	return onehot;
endfunction

// registered request levels, arbiters never see a decode glitch
always_ff @(posedge CLK or negedge rst_n)
begin
	if (!rst_n)
	begin
		bank_fl_req  <= '0;
		bank_bg_req  <= '0;
		bank_spr_req <= '0;
	end
	else
	begin
		bank_fl_req  <= fl_req ? bank_dec(fl_xfer.addr) : '0;	// flash reaches every bank
		bank_bg_req  <= bg_req ? (bank_dec(bg_addr) & BG_REACH) : '0;
		bank_spr_req <= spr_req ? (bank_dec(spr_addr) & SPR_REACH) : '0;
	end
end

// payload follows the request line by the same edge
always_ff @(posedge CLK)
begin
	if (spr_req)
		spr_word <= spr_addr[`VMEM_BANK_AW-1:0];
	if (bg_req)
		bg_word <= bg_addr[`VMEM_BANK_AW-1:0];
	if (fl_req)
		fl_word <= fl_xfer;	// bank bits unused downstream
end

// held requests keep their address, four-phase rule
a_addr_stable: assert property (@(posedge CLK) disable iff (!rst_n)
	(spr_req && $past(spr_req) |-> spr_addr == $past(spr_addr)) and
	(bg_req && $past(bg_req) |-> bg_addr == $past(bg_addr)) and
	(fl_req && $past(fl_req) |-> fl_xfer == $past(fl_xfer)));

// read engines stay on their own banks
a_reach: assert property (@(posedge CLK) disable iff (!rst_n)
	(spr_req |-> SPR_REACH[spr_addr[`VMEM_PA_W-1:`VMEM_BANK_AW]]) and
	(bg_req |-> BG_REACH[bg_addr[`VMEM_PA_W-1:`VMEM_BANK_AW]]));

endmodule

// File: hdl/bank_arbiter.sv
`timescale 1ns/100ps
`include "vmem_consts.svh"

module bank_arbiter
#(
	parameter int BANK_ID = 0	// 0 = bank 1 ... 3 = bank 4
)
(
	input CLK,
	input rst_n,

	input fl_req,
	input bg_req,
	input spr_req,
	input vmem_bus_pkg::periph_req_t fl_word,
	input [`VMEM_BANK_AW-1:0] spr_word,
	input [`VMEM_BANK_AW-1:0] bg_word,
	input vmem_bus_pkg::cpu_req_t cpu,

	output vmem_bus_pkg::bank_port_t port,
	output vmem_arb_pkg::owner_e owner
);

// cpu sees banks 1 and 2 only
localparam bit CPU_BANK = (BANK_ID < 2);
localparam bit CPU_SEL  = (BANK_ID == 1);	// value of cpu addr bit 14

vmem_arb_pkg::arb_state_e state;
vmem_arb_pkg::arb_state_e state_nx;
vmem_arb_pkg::owner_e owner_nx;
logic owner_req;	// request of whoever holds the bank
logic cpu_hit;		// cpu access lands on this bank

always_comb
begin
	case (owner)
		vmem_arb_pkg::OWN_FLASH: owner_req = fl_req;
		vmem_arb_pkg::OWN_BG:    owner_req = bg_req;
		vmem_arb_pkg::OWN_SPR:   owner_req = spr_req;
		default:                 owner_req = 1'b0;
	endcase
end

// grant only out of cpu state with flash > background > sprite
always_comb
begin
	state_nx = state;
	owner_nx = owner;
	case (state)
		vmem_arb_pkg::ST_CPU:
		begin
			if (fl_req)
			begin
				state_nx = vmem_arb_pkg::ST_HELD;
				owner_nx = vmem_arb_pkg::OWN_FLASH;
			end
			else if (bg_req)
			begin
				state_nx = vmem_arb_pkg::ST_HELD;
				owner_nx = vmem_arb_pkg::OWN_BG;
			end
			else if (spr_req)
			begin
				state_nx = vmem_arb_pkg::ST_HELD;
				owner_nx = vmem_arb_pkg::OWN_SPR;
			end
		end
		vmem_arb_pkg::ST_HELD:
		begin
			if (!owner_req)	// holder let go
			begin
				state_nx = vmem_arb_pkg::ST_RELEASE;
				owner_nx = vmem_arb_pkg::OWN_CPU;
			end
		end
		default:	// release lets the router drop its match first
		begin
			state_nx = vmem_arb_pkg::ST_CPU;
			owner_nx = vmem_arb_pkg::OWN_CPU;
		end
	endcase
end

always_ff @(posedge CLK or negedge rst_n)
begin
	if (!rst_n)
	begin
		state <= vmem_arb_pkg::ST_CPU;
		owner <= vmem_arb_pkg::OWN_CPU;
	end
	else
	begin
		state <= state_nx;
		owner <= owner_nx;
	end
end

assign cpu_hit = CPU_BANK && (cpu.addr[`VMEM_CA_W-1] == CPU_SEL);

// bank port mux with cpu fields unless a peripheral holds it
always_comb
begin
	port.addr = cpu.addr[`VMEM_BANK_AW-1:0];
	port.din  = cpu.wdata;
	port.mask = cpu.mask;
	port.wr   = cpu.wr && cpu_hit;	// only the addressed bank writes
	case (owner)
		vmem_arb_pkg::OWN_FLASH:
		begin
			port.addr = fl_word.addr[`VMEM_BANK_AW-1:0];
			port.din  = fl_word.wdata;
			port.mask = '1;		// whole word
			port.wr   = 1'b1;	// rewrites same word while held
		end
		vmem_arb_pkg::OWN_BG:
		begin
			port.addr = bg_word;
			port.wr   = 1'b0;
		end
		vmem_arb_pkg::OWN_SPR:
		begin
			port.addr = spr_word;
			port.wr   = 1'b0;
		end
		default: ;
	endcase
end

// holder's word address stays put as long as its req stays up
a_hold: assert property (@(posedge CLK) disable iff (!rst_n)
	(state == vmem_arb_pkg::ST_HELD && owner_req) |=>
		(!owner_req || port.addr == $past(port.addr)));

endmodule

// File: hdl/bank_ram.sv
`timescale 1ns/100ps
`include "vmem_consts.svh"

module bank_ram
(
	input CLK,
	input vmem_bus_pkg::bank_port_t port,
	output logic [`VMEM_DW-1:0] dout
);

logic [`VMEM_DW-1:0] mem [0:`VMEM_BANK_WORDS-1];

// cleared at load, as the block ram init would be
initial
begin
	for (int i = 0; i < `VMEM_BANK_WORDS; i++)
		mem[i] = '0;
end

always_ff @(posedge CLK)
begin
	for (int b = 0; b < `VMEM_MW; b++)
	begin
		if (port.wr && port.mask[b])	// per byte lane
			mem[port.addr][8*b +: 8] <= port.din[8*b +: 8];
	end
	dout <= mem[port.addr];	// old data on a write cycle
end

endmodule

// File: hdl/resp_router.sv
`timescale 1ns/100ps
`include "vmem_consts.svh"

module resp_router
(
	input CLK,
	input rst_n,

	input vmem_arb_pkg::owner_e owner1,
	input vmem_arb_pkg::owner_e owner2,
	input vmem_arb_pkg::owner_e owner3,
	input vmem_arb_pkg::owner_e owner4,
	input [`VMEM_DW-1:0] dout1,
	input [`VMEM_DW-1:0] dout2,
	input [`VMEM_DW-1:0] dout3,
	input [`VMEM_DW-1:0] dout4,

	input spr_req,
	input bg_req,
	input fl_req,
	input cpu_bank_sel,	// cpu addr bit 14

	output logic spr_ack,
	output logic [`VMEM_DW-1:0] spr_rdata,
	output logic bg_ack,
	output logic [`VMEM_DW-1:0] bg_rdata,
	output logic fl_ack,
	output logic [`VMEM_DW-1:0] cpu_rdata,
	output logic cpu_success
);

logic spr_hit2, spr_hit3;	// sprite owns bank 2 / 3
logic bg_hit2, bg_hit4;
logic fl_hit;			// flash owns any bank
logic spr_hit_q, bg_hit_q, fl_hit_q;	// owned last cycle
logic spr_sel_q;	// 1 = bank 3
logic bg_sel_q;		// 1 = bank 4
logic cpu_sel_q;	// 1 = bank 2

assign spr_hit2 = (owner2 == vmem_arb_pkg::OWN_SPR);
assign spr_hit3 = (owner3 == vmem_arb_pkg::OWN_SPR);
assign bg_hit2  = (owner2 == vmem_arb_pkg::OWN_BG);
assign bg_hit4  = (owner4 == vmem_arb_pkg::OWN_BG);
assign fl_hit   = (owner1 == vmem_arb_pkg::OWN_FLASH) || (owner2 == vmem_arb_pkg::OWN_FLASH) ||
	(owner3 == vmem_arb_pkg::OWN_FLASH) || (owner4 == vmem_arb_pkg::OWN_FLASH);

// rise on the first owned cycle only and hold while req and owner stay
// a stale hold after req drops can not re-raise ack
function automatic logic ack_next(input logic req, input logic hit, input logic hit_q,
	input logic ack);
	return req && hit && (ack || !hit_q);
endfunction

always_ff @(posedge CLK or negedge rst_n)
begin
	if (!rst_n)
	begin
		spr_ack     <= 1'b0;
		bg_ack      <= 1'b0;
		fl_ack      <= 1'b0;
		spr_hit_q   <= 1'b0;
		bg_hit_q    <= 1'b0;
		fl_hit_q    <= 1'b0;
		cpu_success <= 1'b0;
	end
	else
	begin
		spr_ack   <= ack_next(spr_req, spr_hit2 || spr_hit3, spr_hit_q, spr_ack);
		bg_ack    <= ack_next(bg_req, bg_hit2 || bg_hit4, bg_hit_q, bg_ack);
		fl_ack    <= ack_next(fl_req, fl_hit, fl_hit_q, fl_ack);
		spr_hit_q <= spr_hit2 || spr_hit3;
		bg_hit_q  <= bg_hit2 || bg_hit4;
		fl_hit_q  <= fl_hit;
		// cpu access took effect if its bank was cpu owned at this edge
		cpu_success <= ((cpu_bank_sel ? owner2 : owner1) == vmem_arb_pkg::OWN_CPU);
	end
end

// granted bank kept after release
always_ff @(posedge CLK)
begin
	if (spr_hit2 || spr_hit3)
		spr_sel_q <= spr_hit3;
	if (bg_hit2 || bg_hit4)
		bg_sel_q <= bg_hit4;
	cpu_sel_q <= cpu_bank_sel;	// lines up with ram read latency
end

assign spr_rdata = spr_sel_q ? dout3 : dout2;
assign bg_rdata  = bg_sel_q ? dout4 : dout2;
assign cpu_rdata = cpu_sel_q ? dout2 : dout1;

// a new req only rises once the previous ack is gone
a_ack_req: assert property (@(posedge CLK) disable iff (!rst_n)
	($rose(spr_req) |-> !spr_ack) and
	($rose(bg_req) |-> !bg_ack) and
	($rose(fl_req) |-> !fl_ack));

endmodule

// File: hdl/video_mem_top.sv
`timescale 1ns/100ps
`include "vmem_consts.svh"

module video_mem_top
(
	input CLK,
	input rst_n,

	input vmem_bus_pkg::cpu_req_t cpu,
	output [`VMEM_DW-1:0] cpu_rdata,
	output cpu_success,

	input spr_req,
	input [`VMEM_PA_W-1:0] spr_addr,
	output spr_ack,
	output [`VMEM_DW-1:0] spr_rdata,

	input bg_req,
	input [`VMEM_PA_W-1:0] bg_addr,
	output bg_ack,
	output [`VMEM_DW-1:0] bg_rdata,

	input fl_req,
	input vmem_bus_pkg::periph_req_t fl_xfer,
	output fl_ack
);

logic [`VMEM_NBANKS-1:0] bank_fl_req;
logic [`VMEM_NBANKS-1:0] bank_bg_req;
logic [`VMEM_NBANKS-1:0] bank_spr_req;
logic [`VMEM_BANK_AW-1:0] spr_word;
logic [`VMEM_BANK_AW-1:0] bg_word;
vmem_bus_pkg::periph_req_t fl_word;
vmem_bus_pkg::bank_port_t bank_port [`VMEM_NBANKS];
vmem_arb_pkg::owner_e owner [`VMEM_NBANKS];
logic [`VMEM_DW-1:0] dout [`VMEM_NBANKS];

req_decoder dec0
(
	.CLK(CLK),
	.rst_n(rst_n),
	.spr_req(spr_req),
	.spr_addr(spr_addr),
	.bg_req(bg_req),
	.bg_addr(bg_addr),
	.fl_req(fl_req),
	.fl_xfer(fl_xfer),
	.bank_fl_req(bank_fl_req),
	.bank_bg_req(bank_bg_req),
	.bank_spr_req(bank_spr_req),
	.spr_word(spr_word),
	.bg_word(bg_word),
	.fl_word(fl_word)
);

// one arbiter and one ram per bank
for (genvar i = 0; i < `VMEM_NBANKS; i++)
begin : g_bank
	bank_arbiter #(.BANK_ID(i)) arb
	(
		.CLK(CLK),
		.rst_n(rst_n),
		.fl_req(bank_fl_req[i]),
		.bg_req(bank_bg_req[i]),
		.spr_req(bank_spr_req[i]),
		.fl_word(fl_word),
		.spr_word(spr_word),
		.bg_word(bg_word),
		.cpu(cpu),
		.port(bank_port[i]),
		.owner(owner[i])
	);

	bank_ram ram
	(
		.CLK(CLK),
		.port(bank_port[i]),
		.dout(dout[i])
	);
end

resp_router rtr0
(
	.CLK(CLK),
	.rst_n(rst_n),
	.owner1(owner[0]),
	.owner2(owner[1]),
	.owner3(owner[2]),
	.owner4(owner[3]),
	.dout1(dout[0]),
	.dout2(dout[1]),
	.dout3(dout[2]),
	.dout4(dout[3]),
	.spr_req(spr_req),
	.bg_req(bg_req),
	.fl_req(fl_req),
	.cpu_bank_sel(cpu.addr[`VMEM_CA_W-1]),
	.spr_ack(spr_ack),
	.spr_rdata(spr_rdata),
	.bg_ack(bg_ack),
	.bg_rdata(bg_rdata),
	.fl_ack(fl_ack),
	.cpu_rdata(cpu_rdata),
	.cpu_success(cpu_success)
);

endmodule

// File: tests/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// shadow copy of the four banks, starts at zero like the rams
bit [`VMEM_DW-1:0] model_mem [`VMEM_NBANKS][`VMEM_BANK_WORDS];

// per bank count of peripherals seen holding it (ack high, req still high)
int hold_cnt [`VMEM_NBANKS];

function automatic logic [`VMEM_DW-1:0] model_read(input int bank, input int word);
	return model_mem[bank][word];
endfunction

// byte lanes merge one at a time
function automatic void model_write(input int bank, input int word,
	input logic [`VMEM_DW-1:0] data, input logic [`VMEM_MW-1:0] mask);
	for (int b = 0; b < `VMEM_MW; b++)
	begin
		if (mask[b])
			model_mem[bank][word][8*b +: 8] = data[8*b +: 8];	// lane b only
	end
endfunction

function automatic void periph_took(input int bank);
	hold_cnt[bank]++;	// owner is the peripheral from here
endfunction

function automatic void periph_let_go(input int bank);
	hold_cnt[bank]--;	// owner stays until arbiter release
endfunction

// cpu bank 1 is index 0, bank 2 is index 1
function automatic bit cpu_bank_held(input int bank);
	return hold_cnt[bank] != 0;
endfunction

`endif

// File: tests/tb_video_mem.sv
`timescale 1ns/100ps
`include "vmem_consts.svh"

module tb_video_mem;

localparam int N_CPU = 150;	// random cpu accesses
localparam int N_PER = 50;	// random transfers per peripheral
localparam int N_DIR = 40;	// directed transactions, rounded up
localparam int N_TRANS = N_CPU + 3 * N_PER + N_DIR;
localparam int KIND_SPR = 0;
localparam int KIND_BG = 1;
localparam int KIND_FL = 2;

logic CLK;
logic rst_n;
vmem_bus_pkg::cpu_req_t cpu_in;
logic [`VMEM_DW-1:0] cpu_rdata;
logic cpu_success;
logic spr_req;
logic [`VMEM_PA_W-1:0] spr_addr;
logic spr_ack;
logic [`VMEM_DW-1:0] spr_rdata;
logic bg_req;
logic [`VMEM_PA_W-1:0] bg_addr;
logic bg_ack;
logic [`VMEM_DW-1:0] bg_rdata;
logic fl_req;
vmem_bus_pkg::periph_req_t fl_in;
logic fl_ack;

`include "tb_mem_model.svh"

video_mem_top dut0
(
	.CLK(CLK),
	.rst_n(rst_n),
	.cpu(cpu_in),
	.cpu_rdata(cpu_rdata),
	.cpu_success(cpu_success),
	.spr_req(spr_req),
	.spr_addr(spr_addr),
	.spr_ack(spr_ack),
	.spr_rdata(spr_rdata),
	.bg_req(bg_req),
	.bg_addr(bg_addr),
	.bg_ack(bg_ack),
	.bg_rdata(bg_rdata),
	.fl_req(fl_req),
	.fl_xfer(fl_in),
	.fl_ack(fl_ack)
);

initial
begin
	CLK = 1'b0;
	forever
		#20 CLK = ~CLK;	// 40 ns period
end

task automatic abort_run();
	$display("=== FAIL ===");
	$fatal(1, "simulation stopped at first failure");
endtask

task automatic check_word(input string name, input logic [`VMEM_DW-1:0] expected,
	input logic [`VMEM_DW-1:0] actual);
	if (actual !== expected)
	begin
		$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		abort_run();
	end
endtask

task automatic check_owner_flag(input string name, input logic expected, input logic actual);
	if (actual !== expected)
	begin
		$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
		abort_run();
	end
endtask

task automatic step();
	@(posedge CLK);
	#1;	// sample point, outputs settled
endtask

task automatic next_drive();
	@(posedge CLK);
	#2;	// drive point
endtask

function automatic logic ack_of(input int kind);
	case (kind)
		KIND_SPR: return spr_ack;
		KIND_BG:  return bg_ack;
		default:  return fl_ack;
	endcase
endfunction

function automatic logic [`VMEM_DW-1:0] rdata_of(input int kind);
	return (kind == KIND_SPR) ? spr_rdata : bg_rdata;
endfunction

task automatic drive_req(input int kind, input logic val, input logic [`VMEM_PA_W-1:0] addr,
	input logic [`VMEM_DW-1:0] wdata);
	case (kind)
		KIND_SPR:
		begin
			spr_addr = addr;
			spr_req = val;
		end
		KIND_BG:
		begin
			bg_addr = addr;
			bg_req = val;
		end
		default:
		begin
			fl_in.addr = addr;
			fl_in.wdata = wdata;	// stable with req
			fl_req = val;
		end
	endcase
endtask

// one four-phase transfer, called and left at the drive point
task automatic periph_xfer(input string name, input int kind,
	input logic [`VMEM_PA_W-1:0] addr, input logic [`VMEM_DW-1:0] wdata, input int hold);
	int bank;
	int word;
	bank = addr[`VMEM_PA_W-1:`VMEM_BANK_AW];
	word = addr[`VMEM_BANK_AW-1:0];
	check_owner_flag({name, " ack before req"}, 1'b0, ack_of(kind));
	drive_req(kind, 1'b1, addr, wdata);
	do
		step();	// latency depends on other holders
	while (!ack_of(kind));
	periph_took(bank);
	if (kind == KIND_FL)
		model_write(bank, word, wdata, '1);	// write done at ack
	else
		check_word({name, " data at ack"}, model_read(bank, word), rdata_of(kind));
	repeat (hold)
	begin
		step();
		check_owner_flag({name, " ack held"}, 1'b1, ack_of(kind));
		if (kind != KIND_FL)
			check_word({name, " data held"}, model_read(bank, word), rdata_of(kind));
	end
	#1;
	drive_req(kind, 1'b0, addr, wdata);
	periph_let_go(bank);
	step();
	check_owner_flag({name, " ack after req drop"}, 1'b0, ack_of(kind));	// one cycle later
	#1;
endtask

task automatic periph_idle(input string name, input int kind, input int cycles);
	repeat (cycles)
	begin
		step();
		check_owner_flag({name, " ack while idle"}, 1'b0, ack_of(kind));
		#1;
	end
endtask

// cpu access with optional reissue until success
task automatic cpu_access(input string name, input logic wr,
	input logic [`VMEM_CA_W-1:0] addr, input logic [`VMEM_DW-1:0] wdata,
	input logic [`VMEM_MW-1:0] mask, input bit must_ok, input bit retry);
	int bank;
	int word;
	bit held;
	bank = addr[`VMEM_CA_W-1];	// 0 = bank 1, 1 = bank 2
	word = addr[`VMEM_BANK_AW-1:0];
	cpu_in.addr = addr;
	cpu_in.wdata = wdata;
	cpu_in.mask = mask;
	cpu_in.wr = wr;
	do
	begin
		held = cpu_bank_held(bank);	// peripheral surely owns the bank at next edge
		step();
		if (held)
			check_owner_flag({name, " success on held bank"}, 1'b0, cpu_success);
		else if (must_ok)
			check_owner_flag({name, " success"}, 1'b1, cpu_success);
		if (cpu_success && wr)
			model_write(bank, word, wdata, mask);
		else if (cpu_success)
			check_word({name, " read data"}, model_read(bank, word), cpu_rdata);
		#1;
	end
	while (retry && !cpu_success);
	cpu_in.wr = 1'b0;	// no write while idle
endtask

task automatic cpu_random();
	logic [`VMEM_CA_W-1:0] addr;
	logic [31:0] rnd;
	for (int i = 0; i < N_CPU; i++)
	begin
		rnd = $urandom;
		addr = '0;
		addr[3:0] = rnd[3:0];	// small window, reads hit written words
		addr[`VMEM_CA_W-1] = rnd[4];
		cpu_access("cpu random", rnd[5], addr, rnd[31:16], (rnd[7:6] == 2'b00) ? 2'b11 :
			rnd[7:6], 1'b0, 1'b1);
		repeat (rnd[9:8])
			next_drive();
	end
endtask

task automatic periph_random(input string name, input int kind);
	logic [`VMEM_PA_W-1:0] addr;
	logic [31:0] rnd;
	for (int i = 0; i < N_PER; i++)
	begin
		rnd = $urandom;
		addr = '0;
		addr[3:0] = rnd[3:0];
		case (kind)
			KIND_SPR: addr[`VMEM_PA_W-1:`VMEM_BANK_AW] = rnd[4] ? 2'd2 : 2'd1;	// bank 3 or 2
			KIND_BG:  addr[`VMEM_PA_W-1:`VMEM_BANK_AW] = rnd[4] ? 2'd3 : 2'd1;	// bank 4 or 2
			default:  addr[`VMEM_PA_W-1:`VMEM_BANK_AW] = rnd[5:4];
		endcase
		periph_xfer(name, kind, addr, rnd[31:16], int'(rnd[7:6]));
		periph_idle(name, kind, int'(rnd[10:8]) % 5);
	end
endtask

// watchdog, 40 cycles of 40 ns for each planned transaction
initial
begin
	#(40 * N_TRANS * 40);
	$display("watchdog: run exceeded its time limit, a transfer never completed");
	abort_run();
end

initial
begin
	int seed_ret;
	seed_ret = $urandom(32'h73ee5e59);	// one seed, child processes derive from it
	rst_n = 1'b0;
	cpu_in = '0;
	spr_req = 1'b0;
	spr_addr = '0;
	bg_req = 1'b0;
	bg_addr = '0;
	fl_req = 1'b0;
	fl_in = '0;
	repeat (16)
		@(posedge CLK);
	#2 rst_n = 1'b1;
	next_drive();

	check_owner_flag("spr_ack after reset", 1'b0, spr_ack);
	check_owner_flag("bg_ack after reset", 1'b0, bg_ack);
	check_owner_flag("fl_ack after reset", 1'b0, fl_ack);
	cpu_access("bank 1 read after reset", 1'b0, 15'h0123, '0, '0, 1'b1, 1'b0);
	cpu_access("bank 2 read after reset", 1'b0, 15'h7abc, '0, '0, 1'b1, 1'b0);

	// flash load of every bank, then readback through each path
	for (int b = 0; b < `VMEM_NBANKS; b++)
		periph_xfer("flash load", KIND_FL, {b[1:0], 14'h0005}, 16'h1111 * (b + 1), 1);
	cpu_access("cpu read flash bank 1", 1'b0, 15'h0005, '0, '0, 1'b0, 1'b1);
	cpu_access("cpu read flash bank 2", 1'b0, 15'h4005, '0, '0, 1'b0, 1'b1);
	periph_xfer("sprite read bank 2", KIND_SPR, 16'h4005, '0, 0);
	periph_xfer("sprite read bank 3", KIND_SPR, 16'h8005, '0, 2);
	periph_xfer("background read bank 2", KIND_BG, 16'h4005, '0, 0);
	periph_xfer("background read bank 4", KIND_BG, 16'hc005, '0, 1);

	cpu_access("full write bank 1", 1'b1, 15'h0020, 16'hbeef, 2'b11, 1'b1, 1'b0);
	cpu_access("low byte write bank 1", 1'b1, 15'h0020, 16'h1234, 2'b01, 1'b1, 1'b0);
	cpu_access("high byte write bank 2", 1'b1, 15'h4005, 16'h7700, 2'b10, 1'b1, 1'b0);
	cpu_access("merged read bank 1", 1'b0, 15'h0020, '0, '0, 1'b1, 1'b0);
	cpu_access("merged read bank 2", 1'b0, 15'h4005, '0, '0, 1'b1, 1'b0);

	// bank 2 held by sprite, then by background
	for (int k = KIND_SPR; k <= KIND_BG; k++)
	begin
		fork
			periph_xfer("hold bank 2", k, 16'h4005, '0, 10);
			begin
				wait (hold_cnt[1] != 0);
				next_drive();
				cpu_access("write held bank 2", 1'b1, 15'h4005, 16'hdead, 2'b11, 1'b0, 1'b0);
				cpu_access("read held bank 2", 1'b0, 15'h4005, '0, '0, 1'b0, 1'b0);
				cpu_access("write free bank 1", 1'b1, 15'h0021, 16'h5a50 + k, 2'b11, 1'b1, 1'b0);
				cpu_access("read free bank 1", 1'b0, 15'h0021, '0, '0, 1'b1, 1'b0);
			end
		join
		cpu_access("bank 2 after hold", 1'b0, 15'h4005, '0, '0, 1'b0, 1'b1);	// unchanged word
	end

	fork
		cpu_random();
		periph_random("sprite random", KIND_SPR);
		periph_random("background random", KIND_BG);
		periph_random("flash random", KIND_FL);
	join
	$display("=== PASS ===");
	$finish;
end

endmodule

// File: sources.f
+incdir+hdl
+incdir+tests
hdl/vmem_bus_pkg.sv
hdl/vmem_arb_pkg.sv
hdl/req_decoder.sv
hdl/bank_arbiter.sv
hdl/bank_ram.sv
hdl/resp_router.sv
hdl/video_mem_top.sv
tests/tb_video_mem.sv
